/* build.f */
+incdir+common
common/cpu8080_pkg.sv
design/instr_decoder.sv
control/cycle_sequencer.sv
datapath/register_file.sv
datapath/alu.sv
datapath/datapath.sv
design/cpu8080_top.sv
test/tb_checker.sv
test/tb_cpu8080.sv

/* Makefile */
TOOL       = verilator
FLAGS      = --binary --timing
LINT_FLAGS = --lint-only -Wall --timing
TOP        = tb_cpu8080
RTL_TOP    = cpu8080_top
FILELIST   = build.f
OBJ_DIR    = obj_dir
LOG        = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Verification passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* test/tb_cpu8080.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cpu8080_defines.svh"

module tb_cpu8080;
  localparam int NUM_CASES     = 15;
  localparam int RESET_CYCLES  = 16;
  localparam int WRITE_TIMEOUT = 2000;

  typedef struct packed {
    logic [95:0]          prog; // byte 0 in the top bits
    logic [`CPU_ALEN-1:0] poke_addr;
    logic [`CPU_XLEN-1:0] poke_data;
    logic [`CPU_ALEN-1:0] exp_addr;
    logic [`CPU_XLEN-1:0] exp_data;
  } case_t;

  logic                 clk;
  logic                 rst_n = 1'b0;
  logic                 ready = 1'b1;
  logic [`CPU_XLEN-1:0] data_in = '0;
  wire  [`CPU_XLEN-1:0] data_out;
  wire  [`CPU_ALEN-1:0] addr;
  wire                  sync;
  wire                  dbin;
  wire                  write_n;
  logic [`CPU_ALEN-1:0] exp_addr = '0;
  logic [`CPU_XLEN-1:0] exp_data = '0;
  wire  [15:0]          write_count;
  wire  [15:0]          error_count;
  logic [`CPU_XLEN-1:0] mem [0:65535];
  case_t                cases [NUM_CASES];
  case_t                cur = '0;
  logic                 load_mem = 1'b0;
  logic                 stall_en = 1'b0;
  logic [31:0]          lcg_state = 32'h96fb;
  int                   timeouts = 0;

  cpu8080_top i_dut (
    .clk(clk), .rst_n(rst_n), .data_in(data_in), .data_out(data_out), .addr(addr),
    .ready(ready), .sync(sync), .dbin(dbin), .write_n(write_n)
  );

  tb_checker i_checker (
    .clk(clk), .rst_n(rst_n), .write_n(write_n), .sync(sync), .dbin(dbin),
    .addr(addr), .data_out(data_out), .exp_addr(exp_addr), .exp_data(exp_data),
    .write_count(write_count), .error_count(error_count)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic logic [7:0] fill_byte(input logic [15:0] a);
    return a[15:8] ^ {a[6:0], a[7]} ^ 8'h3c;
  endfunction

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // wait states only sampled by the core in T2
  always @(posedge clk) begin
    lcg_state <= lcg_next(lcg_state);
    ready     <= !stall_en || (lcg_state[30:29] != 2'b00);
  end

  always @(posedge clk) begin : memory
    logic [95:0] prog_bytes;
    prog_bytes = cur.prog;
    if (load_mem) begin
      for (int a = 0; a < 65536; a++)
        mem[a[15:0]] = fill_byte(a[15:0]);
      for (int j = 0; j < 12; j++) begin
        mem[j[15:0]] = prog_bytes[95:88];
        prog_bytes   = prog_bytes << 8;
      end
      mem[cur.poke_addr] = cur.poke_data;
    end else if (!write_n) begin
      mem[addr] = data_out;
    end
    data_in <= (sync || dbin) ? mem[addr] : 8'h00;
  end

  task automatic fill_case_table();
    cases[0]  = '{96'h06_5A_70_00_00_00_00_00_00_00_00_00, 16'h4000, 8'h00, 16'h0506, 8'h5A};
    cases[1]  = '{96'h21_34_12_3E_3C_C6_4F_77_00_00_00_00, 16'h4000, 8'h00, 16'h1234, 8'h8B};
    cases[2]  = '{96'h3E_F0_C6_20_06_01_88_77_00_00_00_00, 16'h4000, 8'h00, 16'h0506, 8'h12};
    cases[3]  = '{96'h3E_10_06_20_90_06_30_98_77_00_00_00, 16'h4000, 8'h00, 16'h0506, 8'hBF};
    cases[4]  = '{96'h3E_77_B8_FE_99_77_00_00_00_00_00_00, 16'h4000, 8'h00, 16'h0506, 8'h77};
    cases[5]  = '{96'h3E_F0_C6_20_3E_F3_A1_88_77_00_00_00, 16'h4000, 8'h00, 16'h0506, 8'h03};
    cases[6]  = '{96'h3E_F0_C6_20_3E_5C_AB_88_77_00_00_00, 16'h4000, 8'h00, 16'h0506, 8'h59};
    cases[7]  = '{96'h3E_F0_C6_20_3E_40_B5_88_77_00_00_00, 16'h4000, 8'h00, 16'h0506, 8'h47};
    cases[8]  = '{96'h16_9E_5A_73_00_00_00_00_00_00_00_00, 16'h4000, 8'h00, 16'h0506, 8'h9E};
    cases[9]  = '{96'h0E_33_79_77_00_00_00_00_00_00_00_00, 16'h4000, 8'h00, 16'h0506, 8'h33};
    cases[10] = '{96'h21_00_40_46_21_00_41_70_00_00_00_00, 16'h4000, 8'hC7, 16'h4100, 8'hC7};
    cases[11] = '{96'h21_00_40_3E_11_86_21_01_41_77_00_00, 16'h4000, 8'hC7, 16'h4101, 8'hD8};
    cases[12] = '{96'h01_CD_AB_71_00_00_00_00_00_00_00_00, 16'h4000, 8'h00, 16'h0506, 8'hCD};
    cases[13] = '{96'h11_EF_BE_21_00_20_73_00_00_00_00_00, 16'h4000, 8'h00, 16'h2000, 8'hEF};
    cases[14] = '{96'h3E_05_D6_06_DE_01_77_00_00_00_00_00, 16'h4000, 8'h00, 16'h0506, 8'hFD};
  endtask

  task automatic run_case(input int idx, input logic stalls);
    logic [15:0] writes_before;
    int          waited;
    @(posedge clk);
    rst_n    <= 1'b0;
    stall_en <= stalls;
    cur      <= cases[idx];
    load_mem <= 1'b1;
    exp_addr <= cases[idx].exp_addr;
    exp_data <= cases[idx].exp_data;
    @(posedge clk);
    load_mem <= 1'b0;
    repeat (RESET_CYCLES - 1) @(posedge clk);
    writes_before = write_count;
    rst_n <= 1'b1;
    waited = 0;
    while (write_count == writes_before && waited < WRITE_TIMEOUT) begin
      @(posedge clk);
      waited++;
    end
    if (write_count == writes_before) begin
      $display("timeout: case %0d (wait states %0b) never wrote to memory", idx, stalls);
      timeouts++;
    end
  endtask

  initial begin : run
    int pass;
    int k;
    fill_case_table();
    for (pass = 0; pass < 2; pass++) begin
      for (k = 0; k < NUM_CASES; k++)
        run_case(k, pass == 1); // second pass with wait states
    end
    repeat (4) @(posedge clk);
    $display("writes %0d, check errors %0d, timeouts %0d",
             write_count, error_count, timeouts);
    if (error_count == 16'd0 && timeouts == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* test/tb_checker.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cpu8080_defines.svh"

module tb_checker (
  input  wire                 clk,
  input  wire                 rst_n,
  input  wire                 write_n,
  input  wire                 sync,
  input  wire                 dbin,
  input  wire [`CPU_ALEN-1:0] addr,
  input  wire [`CPU_XLEN-1:0] data_out,
  input  wire [`CPU_ALEN-1:0] exp_addr,
  input  wire [`CPU_XLEN-1:0] exp_data,
  output wire [15:0]          write_count,
  output wire [15:0]          error_count
);
  logic [15:0]          writes = '0;
  logic [15:0]          errors = '0;
  logic                 write_n_q = 1'b1;
  logic                 rst_q = 1'b1; // rst_n seen on the previous edge
  logic                 first_sync = 1'b0;
  logic [`CPU_ALEN-1:0] held_addr = '0;
  logic [`CPU_XLEN-1:0] held_data = '0;
  int                   edge_errors;

  assign write_count = writes;
  assign error_count = errors;

  task automatic flag_error(input string msg);
    $display("error at %0d ns: %s", $time, msg);
    edge_errors++;
  endtask

  always @(posedge clk) begin
    edge_errors = 0;
    // reset state and the cycle that leaves it
    if (!rst_q && (write_n !== 1'b1 || dbin !== 1'b0 || sync !== 1'b0))
      flag_error($sformatf("strobes active around reset, write_n %b dbin %b sync %b",
                           write_n, dbin, sync));
    if (!rst_n) begin
      first_sync <= 1'b1;
    end else if (sync && first_sync) begin
      first_sync <= 1'b0;
      if (addr !== 16'h0000)
        flag_error($sformatf("first fetch at addr %h, expected 0000", addr));
    end
    if (!write_n && write_n_q) begin
      writes    <= writes + 16'd1;
      held_addr <= addr;
      held_data <= data_out;
      if (addr !== exp_addr || data_out !== exp_data)
        flag_error($sformatf("write %h to %h, expected %h to %h",
                             data_out, addr, exp_data, exp_addr));
    end else if (!write_n && (addr !== held_addr || data_out !== held_data)) begin
      flag_error($sformatf("addr %h data_out %h moved during write", addr, data_out));
    end
    write_n_q <= write_n;
    rst_q     <= rst_n;
    errors    <= errors + edge_errors[15:0];
  end

endmodule

`default_nettype wire

/* design/cpu8080_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cpu8080_defines.svh"

module cpu8080_top (
  input  wire                  clk,
  input  wire                  rst_n,
  input  wire [`CPU_XLEN-1:0]  data_in,
  output wire [`CPU_XLEN-1:0]  data_out,
  output wire [`CPU_ALEN-1:0]  addr,
  input  wire                  ready,
  output wire                  sync,
  output wire                  dbin,
  output wire                  write_n
);
  cpu8080_pkg::opcode_u  instr;
  cpu8080_pkg::decoded_t dec;
  cpu8080_pkg::ctrl_t    ctrl;

  instr_decoder i_decoder (.instr(instr), .dec(dec));

  cycle_sequencer i_sequencer (
    .clk(clk), .rst_n(rst_n), .dec(dec), .ready(ready),
    .ctrl(ctrl), .sync(sync), .dbin(dbin), .write_n(write_n)
  );

  datapath i_datapath (
    .clk(clk), .rst_n(rst_n), .ctrl(ctrl), .data_in(data_in),
    .instr(instr), .addr(addr), .data_out(data_out)
  );

endmodule

`default_nettype wire

/* datapath/datapath.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cpu8080_defines.svh"

module datapath (
  input  wire                        clk,
  input  wire                        rst_n,
  input  wire cpu8080_pkg::ctrl_t    ctrl,
  input  wire [`CPU_XLEN-1:0]        data_in,
  output cpu8080_pkg::opcode_u       instr,
  output logic [`CPU_ALEN-1:0]       addr,
  output logic [`CPU_XLEN-1:0]       data_out
);
  logic [`CPU_XLEN-1:0] bus, acc, act, tmp;
  logic [`CPU_XLEN-1:0] reg_rdata, alu_result;
  logic [`CPU_ALEN-1:0] pair_data;
  logic [`CPU_FLAG_C:0] flags;
  logic                 alu_carry;

  always_comb begin
    case (ctrl.bus_src)
      cpu8080_pkg::BUS_DATA_IN: bus = data_in;
      cpu8080_pkg::BUS_ACC:     bus = acc;
      cpu8080_pkg::BUS_TMP:     bus = tmp;
      cpu8080_pkg::BUS_REGS:    bus = reg_rdata;
      default:                  bus = '0;
    endcase
  end

  register_file i_regs (
    .clk       (clk),
    .rst_n     (rst_n),
    .sel       (ctrl.reg_sel),
    .wdata     (ctrl.load_pair ? data_in : bus),
    .write     (ctrl.write_regs | ctrl.load_pair),
    .inc_pc    (ctrl.inc_pc),
    .rdata     (reg_rdata),
    .pair_data (pair_data)
  );

  alu i_alu (
    .op_a      (act),
    .op_b      (tmp),
    .op        (ctrl.alu_op),
    .carry_in  (flags[`CPU_FLAG_C]),
    .result    (alu_result),
    .carry_out (alu_carry)
  );

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      instr <= '0;
      flags <= '0;
    end else begin
      if (ctrl.write_instr)
        instr <= bus;
      if (ctrl.write_carry)
        flags[`CPU_FLAG_C] <= alu_carry;
    end
  end

  always_ff @(posedge clk) begin
    if (ctrl.write_a)
      acc <= ctrl.a_from_alu ? alu_result : bus;
    if (ctrl.write_act)
      act <= acc; // alu left operand
    if (ctrl.write_tmp)
      tmp <= bus;
    if (ctrl.write_adr)
      addr <= pair_data;
    if (ctrl.write_data_out)
      data_out <= bus;
  end

endmodule

`default_nettype wire

/* datapath/alu.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cpu8080_defines.svh"

module alu (
  input  wire [`CPU_XLEN-1:0]          op_a,
  input  wire [`CPU_XLEN-1:0]          op_b,
  input  wire cpu8080_pkg::alu_op_e    op,
  input  wire                          carry_in,
  output logic [`CPU_XLEN-1:0]         result,
  output logic                         carry_out
);
  logic [`CPU_XLEN:0] sum;
  logic [`CPU_XLEN:0] cin;

  // only adc and sbb see the old carry
  assign cin = {{`CPU_XLEN{1'b0}},
                carry_in & (op == cpu8080_pkg::ALU_ADC || op == cpu8080_pkg::ALU_SBB)};

  always_comb begin
    sum       = '0;
    result    = '0;
    carry_out = 1'b0;
    case (op)
      cpu8080_pkg::ALU_ADD, cpu8080_pkg::ALU_ADC: begin
        sum       = {1'b0, op_a} + {1'b0, op_b} + cin;
        result    = sum[`CPU_XLEN-1:0];
        carry_out = sum[`CPU_XLEN];
      end
      cpu8080_pkg::ALU_SUB, cpu8080_pkg::ALU_SBB, cpu8080_pkg::ALU_CMP: begin
        sum       = {1'b0, op_a} - {1'b0, op_b} - cin;
        result    = sum[`CPU_XLEN-1:0];
        carry_out = sum[`CPU_XLEN]; // borrow
      end
      cpu8080_pkg::ALU_ANA: result = op_a & op_b;
      cpu8080_pkg::ALU_XRA: result = op_a ^ op_b;
      default:              result = op_a | op_b;
    endcase
  end

endmodule

`default_nettype wire

/* datapath/register_file.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cpu8080_defines.svh"

module register_file (
  input  wire                          clk,
  input  wire                          rst_n,
  input  wire cpu8080_pkg::reg_sel_t   sel,
  input  wire [`CPU_XLEN-1:0]          wdata,
  input  wire                          write,
  input  wire                          inc_pc,
  output logic [`CPU_XLEN-1:0]         rdata,
  output logic [`CPU_ALEN-1:0]         pair_data
);
  logic [`CPU_XLEN-1:0] b, c, d, e, h, l;
  logic [`CPU_ALEN-1:0] pc;

  always_comb begin
    case (sel.pair)
      `CPU_RP_BC: pair_data = {b, c};
      `CPU_RP_DE: pair_data = {d, e};
      `CPU_RP_HL: pair_data = {h, l};
      default:    pair_data = pc;
    endcase
  end

  assign rdata = (sel.byte_sel == `CPU_RP_LO) ? pair_data[`CPU_XLEN-1:0]
                                              : pair_data[`CPU_ALEN-1:`CPU_XLEN];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      b  <= 8'd1;
      c  <= 8'd2;
      d  <= 8'd3;
      e  <= 8'd4;
      h  <= 8'd5;
      l  <= 8'd6;
      pc <= '0;
    end else begin
      if (inc_pc)
        pc <= pc + 16'd1;
      if (write) begin
        case ({sel.pair, sel.byte_sel})
          {`CPU_RP_BC, `CPU_RP_HI}: b <= wdata;
          {`CPU_RP_BC, `CPU_RP_LO}: c <= wdata;
          {`CPU_RP_DE, `CPU_RP_HI}: d <= wdata;
          {`CPU_RP_DE, `CPU_RP_LO}: e <= wdata;
          {`CPU_RP_HL, `CPU_RP_HI}: h <= wdata;
          {`CPU_RP_HL, `CPU_RP_LO}: l <= wdata;
          default: ; // pc only counts
        endcase
      end
    end
  end

endmodule

`default_nettype wire

/* control/cycle_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cpu8080_defines.svh"

module cycle_sequencer (
  input  wire                          clk,
  input  wire                          rst_n,
  input  wire cpu8080_pkg::decoded_t   dec,
  input  wire                          ready,
  output cpu8080_pkg::ctrl_t           ctrl,
  output logic                         sync,
  output logic                         dbin,
  output logic                         write_n
);
  localparam logic [2:0] T1 = 3'd0;
  localparam logic [2:0] T2 = 3'd1;
  localparam logic [2:0] T3 = 3'd2;
  localparam logic [2:0] T4 = 3'd3;
  localparam logic [2:0] T5 = 3'd4;
  localparam logic [2:0] TR = 3'd5;

  localparam logic [1:0] M1 = 2'd0;
  localparam logic [1:0] M2 = 2'd1;
  localparam logic [1:0] M3 = 2'd2;

  logic [2:0] tstate;
  logic [1:0] mcycle;
  logic       mcycle_end;
  logic       instr_end;
  logic       rd;
  logic       wr;
  cpu8080_pkg::reg_sel_t sss_sel;
  cpu8080_pkg::reg_sel_t ddd_sel;

  // register codes b..l map onto {pair, byte}
  assign sss_sel = dec.sss;
  assign ddd_sel = dec.ddd;

  always_comb begin
    ctrl        = '0;
    ctrl.alu_op = dec.alu_op;
    mcycle_end  = 1'b0;
    instr_end   = 1'b0;
    rd          = 1'b0;
    wr          = 1'b0;

    case ({mcycle, tstate})
      {M1, TR}: instr_end = 1'b1; // leave reset and fetch from pc
      {M1, T1}: ctrl.inc_pc = 1'b1;
      {M1, T2}: begin
        rd               = 1'b1;
        ctrl.bus_src     = cpu8080_pkg::BUS_DATA_IN;
        ctrl.write_instr = 1'b1;
      end
      {M1, T3}: begin
        if ((dec.mov || dec.alu_reg) && !dec.sss_mem) begin
          ctrl.bus_src   = dec.sss_a ? cpu8080_pkg::BUS_ACC : cpu8080_pkg::BUS_REGS;
          ctrl.reg_sel   = sss_sel;
          ctrl.write_tmp = 1'b1;
        end
        ctrl.write_act = dec.alu_reg || dec.alu_imm;
      end
      {M1, T4}: begin
        if (dec.mov && !dec.sss_mem && !dec.ddd_mem) begin
          ctrl.bus_src    = cpu8080_pkg::BUS_TMP;
          ctrl.reg_sel    = ddd_sel;
          ctrl.write_a    = dec.ddd_a;
          ctrl.write_regs = !dec.ddd_a;
        end else if (dec.mov || (dec.alu_reg && dec.sss_mem)) begin
          mcycle_end        = 1'b1;
          ctrl.reg_sel.pair = `CPU_RP_HL; // memory operand at hl
          ctrl.write_adr    = 1'b1;
        end else if (dec.mvi || dec.lxi || dec.alu_imm) begin
          mcycle_end        = 1'b1;
          ctrl.reg_sel.pair = `CPU_RP_PC;
          ctrl.write_adr    = 1'b1;
        end else if (dec.alu_reg) begin
          ctrl.a_from_alu  = 1'b1;
          ctrl.write_a     = !dec.alu_cmp;
          ctrl.write_carry = 1'b1;
          instr_end        = 1'b1;
        end
      end
      {M1, T5}: instr_end = 1'b1; // mov r,r and unknown opcodes
      {M2, T1}: begin
        if (dec.mov && dec.ddd_mem) begin
          ctrl.bus_src        = cpu8080_pkg::BUS_TMP;
          ctrl.write_data_out = 1'b1;
        end
        ctrl.inc_pc = dec.mvi || dec.lxi || dec.alu_imm;
      end
      {M2, T2}: begin
        if (dec.mov && dec.ddd_mem) begin
          wr = 1'b1;
        end else if (dec.lxi) begin
          rd                    = 1'b1;
          ctrl.load_pair        = 1'b1;
          ctrl.reg_sel.pair     = dec.rp;
          ctrl.reg_sel.byte_sel = `CPU_RP_LO;
        end else if (dec.mov || dec.mvi) begin
          rd              = 1'b1;
          ctrl.bus_src    = cpu8080_pkg::BUS_DATA_IN;
          ctrl.reg_sel    = ddd_sel;
          ctrl.write_a    = dec.ddd_a;
          ctrl.write_regs = !dec.ddd_a;
        end else begin
          rd             = 1'b1; // alu operand byte
          ctrl.bus_src   = cpu8080_pkg::BUS_DATA_IN;
          ctrl.write_tmp = 1'b1;
        end
      end
      {M2, T3}: begin
        mcycle_end = 1'b1;
        if (dec.lxi) begin
          ctrl.reg_sel.pair = `CPU_RP_PC;
          ctrl.write_adr    = 1'b1;
        end else begin
          instr_end = 1'b1;
          if (dec.alu_reg || dec.alu_imm) begin
            ctrl.a_from_alu  = 1'b1;
            ctrl.write_a     = !dec.alu_cmp;
            ctrl.write_carry = 1'b1;
          end
        end
      end
      {M3, T1}: ctrl.inc_pc = 1'b1;
      {M3, T2}: begin
        rd                    = 1'b1;
        ctrl.load_pair        = 1'b1; // lxi high byte
        ctrl.reg_sel.pair     = dec.rp;
        ctrl.reg_sel.byte_sel = `CPU_RP_HI;
      end
      {M3, T3}: instr_end = 1'b1;
      default: ;
    endcase

    if (instr_end) begin
      ctrl.reg_sel.pair = `CPU_RP_PC;
      ctrl.write_adr    = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      tstate <= TR;
      mcycle <= M1;
    end else if (tstate != T2 || ready) begin
      if (instr_end) begin
        tstate <= T1;
        mcycle <= M1;
      end else if (mcycle_end) begin
        tstate <= T1;
        mcycle <= mcycle + 2'd1;
      end else begin
        tstate <= tstate + 3'd1;
      end
    end
  end

  assign sync    = tstate == T1;
  assign dbin    = rd;
  assign write_n = !wr;

endmodule

`default_nettype wire

/* design/instr_decoder.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cpu8080_defines.svh"

module instr_decoder (
  input  wire cpu8080_pkg::opcode_u   instr,
  output cpu8080_pkg::decoded_t       dec
);

  always_comb begin
    dec = '0;
    case (instr.mov.group)
      2'b01: dec.mov = !(instr.mov.sss == `CPU_REG_M && instr.mov.ddd == `CPU_REG_M); // not hlt
      2'b00: begin
        dec.mvi = instr.mov.sss == 3'b110 && instr.mov.ddd != `CPU_REG_M;
        // no sp pair here so rp 11 is no lxi
        dec.lxi = !instr.pair.q && instr.pair.low == 3'b001 && instr.pair.rp != `CPU_RP_PC;
      end
      2'b10: dec.alu_reg = 1'b1;
      default: dec.alu_imm = instr.alu.sss == 3'b110;
    endcase

    dec.sss     = instr.mov.sss;
    dec.ddd     = instr.mov.ddd;
    dec.rp      = instr.pair.rp;
    dec.alu_op  = instr.alu.alu_op;

    dec.sss_mem = instr.mov.sss == `CPU_REG_M;
    dec.sss_a   = instr.mov.sss == `CPU_REG_A;
    dec.ddd_mem = instr.mov.ddd == `CPU_REG_M;
    dec.ddd_a   = instr.mov.ddd == `CPU_REG_A;
    dec.alu_cmp = instr.alu.alu_op == cpu8080_pkg::ALU_CMP;
  end

endmodule

`default_nettype wire

/* common/cpu8080_pkg.sv */
`default_nettype none

package cpu8080_pkg;

  typedef enum logic [2:0] {
    ALU_ADD, ALU_ADC, ALU_SUB, ALU_SBB, ALU_ANA, ALU_XRA, ALU_ORA, ALU_CMP
  } alu_op_e;

  typedef enum logic [2:0] {
    BUS_NONE, BUS_DATA_IN, BUS_ACC, BUS_TMP, BUS_REGS
  } bus_src_e;

  typedef struct packed {
    logic [1:0] pair;
    logic       byte_sel; // 1 = low byte
  } reg_sel_t;

  // same opcode byte decoded per instruction class
  typedef union packed {
    struct packed {
      logic [1:0] group;
      logic [2:0] ddd;
      logic [2:0] sss;
    } mov;
    struct packed {
      logic [1:0] group;
      alu_op_e    alu_op;
      logic [2:0] sss;
    } alu;
    struct packed {
      logic [1:0] group;
      logic [1:0] rp;
      logic       q;
      logic [2:0] low;
    } pair;
  } opcode_u;

  typedef struct packed {
    logic       mov, mvi, lxi, alu_reg, alu_imm;
    logic       sss_mem, sss_a, ddd_mem, ddd_a, alu_cmp;
    logic [2:0] sss;
    logic [2:0] ddd;
    logic [1:0] rp;
    alu_op_e    alu_op;
  } decoded_t;

  typedef struct packed {
    bus_src_e bus_src;
    reg_sel_t reg_sel;
    logic     write_regs, write_a, write_act, write_tmp;
    logic     write_instr, write_carry, write_adr, write_data_out;
    logic     a_from_alu;
    alu_op_e  alu_op;
    logic     inc_pc;
    logic     load_pair; // lxi byte straight from data_in
  } ctrl_t;

endpackage

`default_nettype wire

/* common/cpu8080_defines.svh */
`ifndef CPU8080_DEFINES_SVH
`define CPU8080_DEFINES_SVH

`define CPU_XLEN 8
`define CPU_ALEN 16

// pair codes match the rp field of the opcode
`define CPU_RP_BC 2'b00
`define CPU_RP_DE 2'b01
`define CPU_RP_HL 2'b10
`define CPU_RP_PC 2'b11

`define CPU_RP_LO 1'b1
`define CPU_RP_HI 1'b0

`define CPU_REG_M 3'd6
`define CPU_REG_A 3'd7

`define CPU_FLAG_C 0 // only carry survives
`endif
